// File: pmac_pkg.sv
package pmac_pkg;

  //////////////////////////////////////////////////
  // operand and product widths
  //////////////////////////////////////////////////

  localparam int pix_width  = 8;                      // full pixel / weight
  localparam int w4_pix     = 4;                      // narrow operand in MODE_W4
  localparam int opa_width  = 25;                     // dsp a port
  localparam int opb_width  = 18;                     // dsp b port
  localparam int prod_width = opa_width + opb_width;  // 43 bit product
  localparam int acc_width  = 64;

  // spacing of the small products inside the wide product
  localparam int w8_field = 16;
  localparam int w4_field = 9;

  // accumulator slots
  localparam int acc8_width = 24;
  localparam int acc4_width = 16;
  localparam int n_fields8  = 2;   // products per lane in MODE_W8
  localparam int n_fields4  = 4;   // products per lane in MODE_W4

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic signed [pix_width-1:0]  pix_t;
  typedef logic signed [opa_width-1:0]  opa_t;
  typedef logic signed [opb_width-1:0]  opb_t;
  typedef logic signed [prod_width-1:0] prod_t;
  typedef logic [acc_width-1:0]         acc_vec_t;
  typedef logic [acc8_width-1:0]        acc8_t;
  typedef logic [acc4_width-1:0]        acc4_t;

  // packing mode
  typedef enum logic {
    MODE_W8 = 1'b0,   // 2 pixels x 1 weight, 8 bit
    MODE_W4 = 1'b1    // 2 pixels x 2 weights, 4 bit
  } mode_t;

  // operands of one lane for one sample
  typedef struct packed {
    pix_t x0;
    pix_t x1;
    pix_t w0;
    pix_t w1;   // ignored in MODE_W8
  } lane_in_t;

  // combined result and the mode it was formed in
  typedef struct packed {
    acc_vec_t data;
    mode_t    mode;
  } pmac_sum_t;

endpackage

// File: packed_mult.sv
`timescale 1ns/10ps

module packed_mult #(
  parameter int mult_stages = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  pmac_pkg::mode_t    mode,
  input  pmac_pkg::lane_in_t opnd,
  output pmac_pkg::prod_t    prod
);

  pmac_pkg::opa_t  x0_ext;
  pmac_pkg::opa_t  x1_ext;
  pmac_pkg::opb_t  w0_ext;
  pmac_pkg::opb_t  w1_ext;
  pmac_pkg::opa_t  a_pack;
  pmac_pkg::opb_t  b_pack;
  pmac_pkg::opa_t  a_q;
  pmac_pkg::opb_t  b_q;
  pmac_pkg::prod_t mult_out;

  //////////////////////////////////////////////////
  // operand packing
  //////////////////////////////////////////////////

  always_comb begin
    if (mode == pmac_pkg::MODE_W4) begin
      // low nibbles as signed 4 bit values
      x0_ext = {{(pmac_pkg::opa_width - pmac_pkg::w4_pix){opnd.x0[pmac_pkg::w4_pix-1]}},
                opnd.x0[pmac_pkg::w4_pix-1:0]};
      x1_ext = {{(pmac_pkg::opa_width - pmac_pkg::w4_pix){opnd.x1[pmac_pkg::w4_pix-1]}},
                opnd.x1[pmac_pkg::w4_pix-1:0]};
      w0_ext = {{(pmac_pkg::opb_width - pmac_pkg::w4_pix){opnd.w0[pmac_pkg::w4_pix-1]}},
                opnd.w0[pmac_pkg::w4_pix-1:0]};
      w1_ext = {{(pmac_pkg::opb_width - pmac_pkg::w4_pix){opnd.w1[pmac_pkg::w4_pix-1]}},
                opnd.w1[pmac_pkg::w4_pix-1:0]};
      a_pack = x0_ext + (x1_ext <<< (2 * pmac_pkg::w4_field));
      b_pack = w0_ext + (w1_ext <<< pmac_pkg::w4_field);
    end else begin
      x0_ext = {{(pmac_pkg::opa_width - pmac_pkg::pix_width){opnd.x0[pmac_pkg::pix_width-1]}},
                opnd.x0};
      x1_ext = {{(pmac_pkg::opa_width - pmac_pkg::pix_width){opnd.x1[pmac_pkg::pix_width-1]}},
                opnd.x1};
      w0_ext = {{(pmac_pkg::opb_width - pmac_pkg::pix_width){opnd.w0[pmac_pkg::pix_width-1]}},
                opnd.w0};
      w1_ext = '0;  // single weight
      a_pack = x0_ext + (x1_ext <<< pmac_pkg::w8_field);
      b_pack = w0_ext;
    end
  end

  // input register stage
  always_ff @(posedge clk) begin
    if (reset) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= a_pack;
      b_q <= b_pack;
    end
  end

  assign mult_out = a_q * b_q;  // signed 25x18

  // remaining stages behave like the dsp output registers
  generate
    if (mult_stages == 1) begin : g_no_preg
      assign prod = mult_out;
    end else begin : g_preg
      pmac_pkg::prod_t prod_q [mult_stages-1];

      always_ff @(posedge clk) begin
        if (reset) begin
          for (int i = 0; i < mult_stages - 1; i++) begin
            prod_q[i] <= '0;
          end
        end else begin
          prod_q[0] <= mult_out;
          for (int i = 1; i < mult_stages - 1; i++) begin
            prod_q[i] <= prod_q[i-1];
          end
        end
      end

      assign prod = prod_q[mult_stages-2];
    end
  endgenerate

endmodule

// File: mac_lane.sv
`timescale 1ns/10ps

module mac_lane #(
  parameter int mult_stages = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  pmac_pkg::mode_t    mode,
  input  logic               en,
  input  logic               clr,
  input  pmac_pkg::lane_in_t opnd,
  output pmac_pkg::acc_vec_t acc,
  output logic               lane_valid,
  output pmac_pkg::mode_t    acc_mode
);

  pmac_pkg::prod_t        prod;

  logic [mult_stages-1:0] en_sr;
  logic [mult_stages-1:0] clr_sr;
  pmac_pkg::mode_t        mode_sr [mult_stages];
  logic                   en_d;
  logic                   clr_d;
  pmac_pkg::mode_t        mode_d;

  logic [pmac_pkg::n_fields8-1:0] brw8;
  logic [pmac_pkg::n_fields4-1:0] brw4;
  pmac_pkg::acc8_t        fld8 [pmac_pkg::n_fields8];
  pmac_pkg::acc4_t        fld4 [pmac_pkg::n_fields4];

  pmac_pkg::acc_vec_t     acc_base;
  pmac_pkg::acc_vec_t     acc_nxt;
  pmac_pkg::acc_vec_t     acc_q;

  packed_mult #(
    .mult_stages(mult_stages)
  ) mult0 (
    .clk  (clk),
    .reset(reset),
    .mode (mode),
    .opnd (opnd),
    .prod (prod)
  );

  //////////////////////////////////////////////////
  // control delay, matches the multiplier depth
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      en_sr  <= '0;
      clr_sr <= '0;
      for (int i = 0; i < mult_stages; i++) begin
        mode_sr[i] <= pmac_pkg::MODE_W8;
      end
    end else begin
      en_sr[0]   <= en;
      clr_sr[0]  <= clr;
      mode_sr[0] <= mode;
      for (int i = 1; i < mult_stages; i++) begin
        en_sr[i]   <= en_sr[i-1];
        clr_sr[i]  <= clr_sr[i-1];
        mode_sr[i] <= mode_sr[i-1];
      end
    end
  end

  assign en_d   = en_sr[mult_stages-1];   // aligned with prod
  assign clr_d  = clr_sr[mult_stages-1];
  assign mode_d = mode_sr[mult_stages-1];

  //////////////////////////////////////////////////
  // field extraction
  //////////////////////////////////////////////////

  // each field above the lowest owes the sign of the one below
  always_comb begin
    brw8[0] = 1'b0;
    for (int i = 1; i < pmac_pkg::n_fields8; i++) begin
      brw8[i] = prod[i*pmac_pkg::w8_field - 1];
    end
    for (int i = 0; i < pmac_pkg::n_fields8; i++) begin
      fld8[i] = {{(pmac_pkg::acc8_width - pmac_pkg::w8_field)
                  {prod[i*pmac_pkg::w8_field + pmac_pkg::w8_field - 1]}},
                 prod[i*pmac_pkg::w8_field +: pmac_pkg::w8_field]}
                + pmac_pkg::acc8_t'(brw8[i]);
    end
  end

  always_comb begin
    brw4[0] = 1'b0;
    for (int i = 1; i < pmac_pkg::n_fields4; i++) begin
      brw4[i] = prod[i*pmac_pkg::w4_field - 1];
    end
    for (int i = 0; i < pmac_pkg::n_fields4; i++) begin
      fld4[i] = {{(pmac_pkg::acc4_width - pmac_pkg::w4_field)
                  {prod[i*pmac_pkg::w4_field + pmac_pkg::w4_field - 1]}},
                 prod[i*pmac_pkg::w4_field +: pmac_pkg::w4_field]}
                + pmac_pkg::acc4_t'(brw4[i]);
    end
  end

  //////////////////////////////////////////////////
  // accumulators
  //////////////////////////////////////////////////

  assign acc_base = clr_d ? '0 : acc_q;  // clear loads the fresh field

  always_comb begin
    acc_nxt = '0;  // unused slots stay zero
    if (mode_d == pmac_pkg::MODE_W8) begin
      for (int i = 0; i < pmac_pkg::n_fields8; i++) begin
        acc_nxt[i*pmac_pkg::acc8_width +: pmac_pkg::acc8_width] =
          acc_base[i*pmac_pkg::acc8_width +: pmac_pkg::acc8_width] + fld8[i];
      end
    end else begin
      for (int i = 0; i < pmac_pkg::n_fields4; i++) begin
        acc_nxt[i*pmac_pkg::acc4_width +: pmac_pkg::acc4_width] =
          acc_base[i*pmac_pkg::acc4_width +: pmac_pkg::acc4_width] + fld4[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q      <= '0;
      lane_valid <= 1'b0;
      acc_mode   <= pmac_pkg::MODE_W8;
    end else begin
      lane_valid <= en_d;   // one pulse per sample
      if (en_d) begin
        acc_q    <= acc_nxt;
        acc_mode <= mode_d;
      end
    end
  end

  assign acc = acc_q;

endmodule

// File: lane_combine.sv
`timescale 1ns/10ps

module lane_combine (
  input  logic                clk,
  input  logic                reset,
  input  pmac_pkg::acc_vec_t  acc0,
  input  pmac_pkg::acc_vec_t  acc1,
  input  logic                in_valid,
  input  pmac_pkg::mode_t     acc_mode,
  output pmac_pkg::pmac_sum_t sum,
  output logic                sum_valid
);

  pmac_pkg::acc8_t     sum8 [pmac_pkg::n_fields8];
  pmac_pkg::acc4_t     sum4 [pmac_pkg::n_fields4];
  pmac_pkg::acc_vec_t  sum_data;
  pmac_pkg::pmac_sum_t sum_q;

  //////////////////////////////////////////////////
  // field-wise sums, no carry across fields
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < pmac_pkg::n_fields8; i++) begin
      sum8[i] = acc0[i*pmac_pkg::acc8_width +: pmac_pkg::acc8_width]
              + acc1[i*pmac_pkg::acc8_width +: pmac_pkg::acc8_width];
    end
  end

  always_comb begin
    for (int i = 0; i < pmac_pkg::n_fields4; i++) begin
      sum4[i] = acc0[i*pmac_pkg::acc4_width +: pmac_pkg::acc4_width]
              + acc1[i*pmac_pkg::acc4_width +: pmac_pkg::acc4_width];
    end
  end

  // pick the slot layout of the mode
  always_comb begin
    sum_data = '0;
    if (acc_mode == pmac_pkg::MODE_W8) begin
      for (int i = 0; i < pmac_pkg::n_fields8; i++) begin
        sum_data[i*pmac_pkg::acc8_width +: pmac_pkg::acc8_width] = sum8[i];
      end
    end else begin
      for (int i = 0; i < pmac_pkg::n_fields4; i++) begin
        sum_data[i*pmac_pkg::acc4_width +: pmac_pkg::acc4_width] = sum4[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_q     <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= in_valid;
      if (in_valid) begin
        sum_q.data <= sum_data;
        sum_q.mode <= acc_mode;   // mode travels with the result
      end
    end
  end

  assign sum = sum_q;

endmodule

// File: pmac_top.sv
`timescale 1ns/10ps

module pmac_top #(
  parameter int mult_stages = 2
) (
  input  logic                clk,
  input  logic                reset,
  input  pmac_pkg::mode_t     mode,
  input  logic                en,
  input  logic                clr,
  input  pmac_pkg::lane_in_t  lane0_in,
  input  pmac_pkg::lane_in_t  lane1_in,
  output pmac_pkg::pmac_sum_t sum,
  output logic                sum_valid
);

  pmac_pkg::acc_vec_t lane0_acc;
  pmac_pkg::acc_vec_t lane1_acc;
  logic               lane0_valid;
  logic               lane1_valid;   // must match lane0_valid
  pmac_pkg::mode_t    lane0_mode;

  //////////////////////////////////////////////////
  // two lanes on different rows
  //////////////////////////////////////////////////

  mac_lane #(
    .mult_stages(mult_stages)
  ) lane0 (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .en        (en),
    .clr       (clr),
    .opnd      (lane0_in),
    .acc       (lane0_acc),
    .lane_valid(lane0_valid),
    .acc_mode  (lane0_mode)
  );

  mac_lane #(
    .mult_stages(mult_stages)
  ) lane1 (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .en        (en),
    .clr       (clr),
    .opnd      (lane1_in),
    .acc       (lane1_acc),
    .lane_valid(lane1_valid),
    .acc_mode  ()              // same as lane 0
  );

  // lane 0 timing drives the combiner
  lane_combine combine0 (
    .clk      (clk),
    .reset    (reset),
    .acc0     (lane0_acc),
    .acc1     (lane1_acc),
    .in_valid (lane0_valid),
    .acc_mode (lane0_mode),
    .sum      (sum),
    .sum_valid(sum_valid)
  );

endmodule

// File: pmac_asserts.sv
`timescale 1ns/10ps

module pmac_asserts #(
  parameter int latency = 4
) (
  input logic            clk,
  input logic            reset,
  input pmac_pkg::mode_t mode,
  input logic            en,
  input logic            clr,
  input logic            sum_valid,
  input logic            lane0_valid,
  input logic            lane1_valid
);

  //////////////////////////////////////////////////
  // protocol checks on the top level
  //////////////////////////////////////////////////

  // quiet through reset and just after it
  a_reset_quiet: assert property (@(posedge clk) reset |=> !sum_valid)
    else $error("sum_valid high in reset");
  a_after_reset: assert property (@(posedge clk) $fell(reset) |=> !sum_valid)
    else $error("sum_valid high right after reset");

  a_latency: assert property (@(posedge clk) disable iff (reset)
    sum_valid == $past(en, latency))
    else $error("sum_valid does not follow en by the pipeline latency");

  a_lanes_agree: assert property (@(posedge clk) lane0_valid == lane1_valid)
    else $error("lane valid pulses differ");

  // mode may only move together with a clear
  a_mode_stable: assert property (@(posedge clk) disable iff (reset)
    (en && $past(en) && !clr) |-> $stable(mode))
    else $error("mode changed without clr");

endmodule

bind pmac_top pmac_asserts #(.latency(mult_stages + 2)) asserts0 (
  .clk(clk), .reset(reset), .mode(mode), .en(en), .clr(clr),
  .sum_valid(sum_valid), .lane0_valid(lane0_valid), .lane1_valid(lane1_valid)
);

// File: pmac_tb.sv
`timescale 1ns/10ps

module pmac_tb;

  localparam int mult_stages     = 2;
  localparam int latency         = mult_stages + 2;
  localparam int clk_period      = 100;
  localparam int reset_cycles    = 10;
  localparam int wrap_samples    = 520;   // 520 x 128 runs past 2^16
  localparam int n_samples       = 1 + 20 + 20 + 8 + 8 + wrap_samples;
  localparam int watchdog_cycles = n_samples * 10 + reset_cycles;

  logic                clk;
  logic                reset;
  pmac_pkg::mode_t     mode;
  logic                en;
  logic                clr;
  pmac_pkg::lane_in_t  lane0_in;
  pmac_pkg::lane_in_t  lane1_in;
  pmac_pkg::pmac_sum_t sum;
  logic                sum_valid;

  int          cyc = 0;
  int          model_f [4];            // true field sums over both lanes
  logic [64:0] exp_q [$];
  int          due_q [$];              // cycle each result is due
  logic [64:0] prev_sum = '0;
  logic [15:0] lfsr_state = 16'd78;
  string       test_name = "reset";

  pmac_top #(.mult_stages(mult_stages)) dut0 (
    .clk(clk), .reset(reset), .mode(mode), .en(en), .clr(clr),
    .lane0_in(lane0_in), .lane1_in(lane1_in), .sum(sum), .sum_valid(sum_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // stimulus and reference model
  //////////////////////////////////////////////////

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [7:0] lfsr_bits(input int n);
    logic [7:0] val;
    logic       fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      val = {val[6:0], fb};
    end
    return val;
  endfunction

  function automatic pmac_pkg::lane_in_t random_lane();
    pmac_pkg::lane_in_t s;
    s.x0 = lfsr_bits(8);
    s.x1 = lfsr_bits(8);
    s.w0 = lfsr_bits(8);
    s.w1 = lfsr_bits(8);
    return s;
  endfunction

  // low bits of an operand as a signed number
  function automatic int sext(input logic [7:0] v, input int bits);
    int r;
    r = int'(v) % (1 << bits);
    if (r >= (1 << (bits - 1))) r -= 1 << bits;
    return r;
  endfunction

  function automatic void add_products(input pmac_pkg::mode_t m, input pmac_pkg::lane_in_t s);
    int b;
    b = (m == pmac_pkg::MODE_W8) ? 8 : 4;
    model_f[0] += sext(s.x0, b) * sext(s.w0, b);
    if (m == pmac_pkg::MODE_W8) begin
      model_f[1] += sext(s.x1, b) * sext(s.w0, b);   // one weight
    end else begin
      model_f[1] += sext(s.x0, b) * sext(s.w1, b);
      model_f[2] += sext(s.x1, b) * sext(s.w0, b);
      model_f[3] += sext(s.x1, b) * sext(s.w1, b);
    end
  endfunction

  function automatic logic [64:0] expected_sum(input pmac_pkg::mode_t m);
    logic [63:0] d;
    if (m == pmac_pkg::MODE_W8) d = {16'h0, model_f[1][23:0], model_f[0][23:0]};
    else d = {model_f[3][15:0], model_f[2][15:0], model_f[1][15:0], model_f[0][15:0]};
    return {d, m};
  endfunction

  task automatic check_value(input string what, input logic [64:0] expected,
                             input logic [64:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic drive_sample(input pmac_pkg::mode_t m, input logic c,
                              input pmac_pkg::lane_in_t in0, input pmac_pkg::lane_in_t in1);
    @(posedge clk);
    mode     <= m;
    en       <= 1'b1;
    clr      <= c;
    lane0_in <= in0;
    lane1_in <= in1;
    if (c) begin
      foreach (model_f[i]) model_f[i] = 0;
    end
    add_products(m, in0);
    add_products(m, in1);
    exp_q.push_back(expected_sum(m));
    due_q.push_back(cyc + latency + 1);   // en is taken at the next edge
  endtask

  task automatic finish_samples();
    @(posedge clk);
    en  <= 1'b0;
    clr <= 1'b0;
    while (due_q.size() != 0) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // result monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    logic [64:0] exp_val;
    if (!reset) begin
      if (sum_valid) begin
        if (due_q.size() == 0) begin
          report_error("sum_valid pulsed with no sample in flight");
        end else if (due_q[0] != cyc) begin
          report_error("sum_valid came at the wrong cycle");
        end else begin
          exp_val = exp_q.pop_front();
          void'(due_q.pop_front());
          check_value("sum", exp_val, sum);
        end
      end else if (due_q.size() != 0 && cyc >= due_q[0]) begin
        report_error($sformatf("no sum_valid within %0d cycles of a sample", latency));
      end else if (sum !== prev_sum) begin
        report_error("sum changed while sum_valid was low");
      end
      prev_sum = sum;
    end
  end

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic check_reset_clear();
    pmac_pkg::lane_in_t in0;
    pmac_pkg::lane_in_t in1;
    test_name = "reset_clear";
    repeat (3) @(negedge clk);
    check_value("sum_valid", 65'd0, 65'(sum_valid));
    check_value("sum", 65'd0, sum);
    in0 = random_lane();
    in1 = random_lane();
    drive_sample(pmac_pkg::MODE_W8, 1'b1, in0, in1);
    finish_samples();
  endtask

  // back to back random samples with a clear on the first
  task automatic accumulate_random(input pmac_pkg::mode_t m, input string name);
    pmac_pkg::lane_in_t in0;
    pmac_pkg::lane_in_t in1;
    test_name = name;
    for (int i = 0; i < 20; i++) begin
      in0 = random_lane();
      in1 = random_lane();
      if (i == 7) begin
        in0 = 32'h80808080;   // -128 in every operand
        in1 = in0;
      end
      if (i == 8) in0 = 32'h80807f00;   // most negative products borrow
      drive_sample(m, i == 0, in0, in1);
    end
    finish_samples();
  endtask

  task automatic spaced_samples();
    pmac_pkg::lane_in_t in0;
    pmac_pkg::lane_in_t in1;
    logic [7:0]         r;
    test_name = "gaps";
    for (int i = 0; i < 8; i++) begin
      in0 = random_lane();
      in1 = random_lane();
      drive_sample(pmac_pkg::MODE_W4, 1'b0, in0, in1);
      r = lfsr_bits(2);
      repeat (1 + int'(r[1:0])) begin
        @(posedge clk);
        en <= 1'b0;
      end
    end
    finish_samples();
  endtask

  task automatic switch_mode();
    pmac_pkg::lane_in_t in0;
    pmac_pkg::lane_in_t in1;
    test_name = "mode_switch";
    for (int i = 0; i < 4; i++) begin
      in0 = random_lane();
      in1 = random_lane();
      drive_sample(pmac_pkg::MODE_W8, i == 0, in0, in1);
    end
    // all four fields nonzero right after the switch
    drive_sample(pmac_pkg::MODE_W4, 1'b1, 32'h02030506, 32'hfd0307f5);
    for (int i = 0; i < 3; i++) begin
      in0 = random_lane();
      in1 = random_lane();
      drive_sample(pmac_pkg::MODE_W4, 1'b0, in0, in1);
    end
    finish_samples();
    check_value("mode", 65'(pmac_pkg::MODE_W4), 65'(sum.mode));
  endtask

  // field 0 climbs by 128, field 1 falls by 112, fields 2 and 3 stay zero
  task automatic wrap_field();
    test_name = "wrap";
    for (int i = 0; i < wrap_samples; i++) begin
      drive_sample(pmac_pkg::MODE_W4, i == 0, 32'hf800f807, 32'hf800f807);
    end
    finish_samples();
  endtask

  initial begin
    reset    = 1'b1;
    mode     = pmac_pkg::MODE_W8;
    en       = 1'b0;
    clr      = 1'b0;
    lane0_in = '0;
    lane1_in = '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    check_reset_clear();
    accumulate_random(pmac_pkg::MODE_W8, "w8_accum");
    accumulate_random(pmac_pkg::MODE_W4, "w4_accum");
    spaced_samples();
    switch_mode();
    wrap_field();
    $display("Test passed");
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("ERROR: watchdog expired after %0d cycles, results stopped coming", watchdog_cycles);
    $display("Test failed");
    $fatal(1, "watchdog");
  end

endmodule

// File: pmac_top.f
pmac_pkg.sv
packed_mult.sv
mac_lane.sv
lane_combine.sv
pmac_top.sv
pmac_asserts.sv
pmac_tb.sv

// File: run.sh
#!/bin/bash
# build and run the pmac testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pmac_tb -f pmac_top.f -o pmac_sim \
  && ./obj_dir/pmac_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test passed" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
